// File: Bender.yml
package:
  name: frogger_display

sources:
  - source/video_pkg.sv
  - source/game_pkg.sv
  - source/video_timing.sv
  - source/frog_control.sv
  - source/frog_sprite.sv
  - source/lane_background.sv
  - source/pixel_mixer.sv
  - source/frogger_display.sv
  - target: test
    files:
      - tb/frogger_display_assertions.sv
      - tb/frogger_display_tb.sv

// File: source/frog_control.sv
`timescale 1ns/100ps

module frog_control #(
    parameter int H_ACTIVE  = 640,
    parameter int V_ACTIVE  = 480,
    parameter int MOVE_STEP = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  video_pkg::raster_t  raster,
    input  logic                btn_up,
    input  logic                btn_down,
    input  logic                btn_left,
    input  logic                btn_right,
    output game_pkg::frog_pos_t frog
);

    localparam logic [9:0] X_MAX   = 10'(H_ACTIVE - game_pkg::FROG_SIZE);
    localparam logic [9:0] Y_MAX   = 10'(V_ACTIVE - game_pkg::FROG_SIZE);
    localparam logic [9:0] X_START = 10'(H_ACTIVE / 2 - game_pkg::FROG_SIZE / 2);
    localparam logic [9:0] STEP    = 10'(MOVE_STEP);

    logic                req_up;
    logic                req_down;
    logic                req_left;
    logic                req_right;
    logic [10:0]         x_inc;
    logic [10:0]         y_inc;
    game_pkg::frog_pos_t frog_next;

    assign x_inc = {1'b0, frog.x} + {1'b0, STEP};
    assign y_inc = {1'b0, frog.y} + {1'b0, STEP};

    // opposite requests cancel and each axis clamps to the field.
    always_comb begin
        frog_next = frog;
        if (req_left && !req_right) begin
            frog_next.x = (frog.x < STEP) ? 10'd0 : frog.x - STEP;
        end else if (req_right && !req_left) begin
            frog_next.x = (x_inc > {1'b0, X_MAX}) ? X_MAX : x_inc[9:0];
        end
        if (req_up && !req_down) begin
            frog_next.y = (frog.y < STEP) ? 10'd0 : frog.y - STEP;
        end else if (req_down && !req_up) begin
            frog_next.y = (y_inc > {1'b0, Y_MAX}) ? Y_MAX : y_inc[9:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frog      <= '{x: X_START, y: Y_MAX};
            req_up    <= 1'b0;
            req_down  <= 1'b0;
            req_left  <= 1'b0;
            req_right <= 1'b0;
        end else if (raster.frame_start) begin
            frog      <= frog_next;  // pixel 0,0 is never a frog pixel.
            req_up    <= btn_up;     // served requests drop while a held button stays.
            req_down  <= btn_down;
            req_left  <= btn_left;
            req_right <= btn_right;
        end else begin
            req_up    <= req_up | btn_up;
            req_down  <= req_down | btn_down;
            req_left  <= req_left | btn_left;
            req_right <= req_right | btn_right;
        end
    end

endmodule

// File: source/frog_sprite.sv
`timescale 1ns/100ps

module frog_sprite (
    input  logic                clk,
    input  logic                rst_n,
    input  video_pkg::raster_t  raster,
    input  game_pkg::frog_pos_t frog,
    output game_pkg::layer_px_t layer
);

    logic [10:0]         x_end;
    logic [10:0]         y_end;
    logic                in_frog;
    logic [9:0]          lx;
    logic [9:0]          ly;
    game_pkg::layer_px_t px;

    // inclusive box test in sprite coordinates
    function automatic logic in_box(
        input logic [9:0] u,
        input logic [9:0] v,
        input int         x_lo,
        input int         x_hi,
        input int         y_lo,
        input int         y_hi
    );
        return (int'(u) >= x_lo) && (int'(u) <= x_hi) &&
               (int'(v) >= y_lo) && (int'(v) <= y_hi);
    endfunction

    assign x_end = {1'b0, frog.x} + 11'(game_pkg::FROG_SIZE);
    assign y_end = {1'b0, frog.y} + 11'(game_pkg::FROG_SIZE);

    assign in_frog = (raster.col > frog.x) && ({1'b0, raster.col} < x_end) &&
                     (raster.row > frog.y) && ({1'b0, raster.row} <= y_end);

    assign lx = raster.col - frog.x;
    assign ly = raster.row - frog.y;

    // ======================================
    // shape table, first match wins
    // ======================================

    always_comb begin
        px = '0;
        if (in_frog) begin
            px.opaque = 1'b1;
            if (in_box(lx, ly, 9, 10, 2, 4) || in_box(lx, ly, 21, 22, 2, 4)) begin
                px.color = game_pkg::PUPIL;
            end else if (in_box(lx, ly, 6, 8, 2, 6) || in_box(lx, ly, 23, 25, 2, 6) ||
                         in_box(lx, ly, 6, 10, 5, 6) || in_box(lx, ly, 21, 25, 4, 6)) begin
                px.color = game_pkg::EYE_WHITE;
            end else if (in_box(lx, ly, 12, 19, 16, 18)) begin
                px.color = game_pkg::MOUTH;  // sits inside the body center.
            end else if (in_box(lx, ly, 10, 21, 10, 18)) begin
                px.color = game_pkg::YELLOW;
            end else if (in_box(lx, ly, 4, 27, 6, 20)) begin
                px.color = game_pkg::LIGHT_GREEN;
            end else if (in_box(lx, ly, 2, 7, 20, 25) || in_box(lx, ly, 24, 29, 20, 25)) begin
                px.color = game_pkg::LIGHT_GREEN;  // legs.
            end else begin
                px.opaque = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer <= '0;
        end else begin
            layer <= px;
        end
    end

endmodule

// File: source/frogger_display.sv
`timescale 1ns/100ps

module frogger_display #(
    parameter int H_ACTIVE    = 640,
    parameter int H_FRONT     = 16,
    parameter int H_SYNC      = 96,
    parameter int H_BACK      = 48,
    parameter int V_ACTIVE    = 480,
    parameter int V_FRONT     = 10,
    parameter int V_SYNC      = 2,
    parameter int V_BACK      = 33,
    parameter int MOVE_STEP   = 8,
    parameter int SCROLL_STEP = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              btn_up,
    input  logic              btn_down,
    input  logic              btn_left,
    input  logic              btn_right,
    output video_pkg::color_t color,
    output logic              hsync,
    output logic              vsync,
    output logic              active
);

    video_pkg::raster_t  raster;
    game_pkg::frog_pos_t frog;
    game_pkg::layer_px_t sprite_px;
    game_pkg::layer_px_t background_px;

    // ======================================
    // raster and frog position
    // ======================================

    video_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) i_video_timing (
        .clk   (clk),
        .rst_n (rst_n),
        .raster(raster)
    );

    frog_control #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE),
        .MOVE_STEP(MOVE_STEP)
    ) i_frog_control (
        .clk      (clk),
        .rst_n    (rst_n),
        .raster   (raster),
        .btn_up   (btn_up),
        .btn_down (btn_down),
        .btn_left (btn_left),
        .btn_right(btn_right),
        .frog     (frog)
    );

    // ======================================
    // layers and output
    // ======================================

    frog_sprite i_frog_sprite (
        .clk   (clk),
        .rst_n (rst_n),
        .raster(raster),
        .frog  (frog),
        .layer (sprite_px)
    );

    lane_background #(
        .V_ACTIVE   (V_ACTIVE),
        .SCROLL_STEP(SCROLL_STEP)
    ) i_lane_background (
        .clk   (clk),
        .rst_n (rst_n),
        .raster(raster),
        .layer (background_px)
    );

    pixel_mixer i_pixel_mixer (
        .clk       (clk),
        .rst_n     (rst_n),
        .raster    (raster),
        .sprite    (sprite_px),
        .background(background_px),
        .color     (color),
        .hsync     (hsync),
        .vsync     (vsync),
        .active    (active)
    );

endmodule

// File: source/game_pkg.sv
package game_pkg;

    // ======================================
    // game objects
    // ======================================

    typedef struct packed {
        logic [9:0] x;  // upper-left corner of the frog.
        logic [9:0] y;
    } frog_pos_t;

    typedef struct packed {
        video_pkg::color_t color;
        logic              opaque;  // layer covers what lies below.
    } layer_px_t;

    // ======================================
    // palette
    // ======================================

    localparam video_pkg::color_t LIGHT_GREEN = 6'b001100;
    localparam video_pkg::color_t YELLOW      = 6'b110100;
    localparam video_pkg::color_t EYE_WHITE   = 6'b111111;
    localparam video_pkg::color_t PUPIL       = 6'b000001;
    localparam video_pkg::color_t MOUTH       = 6'b100000;  // dark red.

    localparam video_pkg::color_t GRASS = 6'b000100;
    localparam video_pkg::color_t WATER = 6'b000011;
    localparam video_pkg::color_t ROAD  = 6'b010101;
    localparam video_pkg::color_t DASH  = 6'b101010;

    // sprite and lane geometry
    localparam int FROG_SIZE      = 32;  // shape table is drawn for this edge.
    localparam int LANE_HEIGHT    = 32;  // power of two.
    localparam int DASH_PERIOD    = 32;
    localparam int DASH_LEN       = 16;
    localparam int DASH_ROW_FIRST = 15;
    localparam int DASH_ROW_LAST  = 16;

endpackage

// File: source/lane_background.sv
`timescale 1ns/100ps

module lane_background #(
    parameter int V_ACTIVE    = 480,
    parameter int SCROLL_STEP = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  video_pkg::raster_t  raster,
    output game_pkg::layer_px_t layer
);

    localparam int         BAND_SHIFT = $clog2(game_pkg::LANE_HEIGHT);
    localparam logic [9:0] LAST_BAND  = 10'(V_ACTIVE / game_pkg::LANE_HEIGHT - 1);
    localparam logic [9:0] BAND_MASK  = 10'(game_pkg::LANE_HEIGHT - 1);
    localparam logic [9:0] DASH_MASK  = 10'(game_pkg::DASH_PERIOD - 1);
    localparam logic [9:0] STEP       = 10'(SCROLL_STEP);

    logic [9:0]          offset;
    logic                scroll_armed;  // first frame after reset keeps offset 0.
    logic [9:0]          band;
    logic [9:0]          band_row;
    logic [9:0]          phase;
    logic                dash;
    game_pkg::layer_px_t px;

    assign band     = raster.row >> BAND_SHIFT;
    assign band_row = raster.row & BAND_MASK;
    assign phase    = (raster.col + offset) & DASH_MASK;
    assign dash     = (int'(band_row) >= game_pkg::DASH_ROW_FIRST) &&
                      (int'(band_row) <= game_pkg::DASH_ROW_LAST) &&
                      (int'(phase) < game_pkg::DASH_LEN);

    always_comb begin
        px.opaque = 1'b1;  // background is always solid.
        if (band == 10'd0 || band >= LAST_BAND) begin
            px.color = game_pkg::GRASS;
        end else if (band[0]) begin
            px.color = game_pkg::WATER;
        end else begin
            px.color = dash ? game_pkg::DASH : game_pkg::ROAD;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            offset       <= '0;
            scroll_armed <= 1'b0;
            layer        <= '0;
        end else begin
            layer <= px;
            if (raster.frame_start) begin
                scroll_armed <= 1'b1;
                if (scroll_armed) begin
                    offset <= offset + STEP;  // wraps cleanly since the period divides 1024.
                end
            end
        end
    end

endmodule

// File: source/pixel_mixer.sv
`timescale 1ns/100ps

module pixel_mixer (
    input  logic                clk,
    input  logic                rst_n,
    input  video_pkg::raster_t  raster,
    input  game_pkg::layer_px_t sprite,
    input  game_pkg::layer_px_t background,
    output video_pkg::color_t   color,
    output logic                hsync,
    output logic                vsync,
    output logic                active
);

    video_pkg::raster_t raster_d;  // lines up with the registered layers.
    video_pkg::color_t  mixed;

    assign mixed = sprite.opaque ? sprite.color : background.color;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raster_d <= video_pkg::RASTER_IDLE;
            color    <= '0;
            hsync    <= 1'b1;
            vsync    <= 1'b1;
            active   <= 1'b0;
        end else begin
            raster_d <= raster;
            color    <= raster_d.active ? mixed : 6'd0;  // black in blanking.
            hsync    <= raster_d.hsync;
            vsync    <= raster_d.vsync;
            active   <= raster_d.active;
        end
    end

endmodule

// File: source/video_pkg.sv
package video_pkg;

    // ======================================
    // raster position and sync
    // ======================================

    typedef struct packed {
        logic [9:0] col;          // pixel column including blanking.
        logic [9:0] row;          // line number including blanking.
        logic       active;       // inside the visible area.
        logic       hsync;        // low during the horizontal sync pulse.
        logic       vsync;        // low during the vertical sync lines.
        logic       frame_start;  // high for column 0, row 0 only.
    } raster_t;

    // 2 bits each of red, green and blue
    typedef logic [5:0] color_t;

    // idle raster with syncs released and nothing visible.
    localparam raster_t RASTER_IDLE = '{
        col:         10'd0,
        row:         10'd0,
        active:      1'b0,
        hsync:       1'b1,
        vsync:       1'b1,
        frame_start: 1'b0
    };

endpackage

// File: source/video_timing.sv
`timescale 1ns/100ps

module video_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic               clk,
    input  logic               rst_n,
    output video_pkg::raster_t raster
);

    localparam logic [9:0] H_LAST     = 10'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam logic [9:0] V_LAST     = 10'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
    localparam logic [9:0] H_VISIBLE  = 10'(H_ACTIVE);
    localparam logic [9:0] V_VISIBLE  = 10'(V_ACTIVE);
    localparam logic [9:0] H_SYNC_ON  = 10'(H_ACTIVE + H_FRONT);
    localparam logic [9:0] H_SYNC_OFF = 10'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [9:0] V_SYNC_ON  = 10'(V_ACTIVE + V_FRONT);
    localparam logic [9:0] V_SYNC_OFF = 10'(V_ACTIVE + V_FRONT + V_SYNC);

    logic [9:0]         h_cnt;
    logic [9:0]         v_cnt;
    video_pkg::raster_t pos;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? 10'd0 : v_cnt + 10'd1;  // wraps at frame total.
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    always_comb begin
        pos.col         = h_cnt;
        pos.row         = v_cnt;
        pos.active      = (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);
        pos.hsync       = !((h_cnt >= H_SYNC_ON) && (h_cnt < H_SYNC_OFF));
        pos.vsync       = !((v_cnt >= V_SYNC_ON) && (v_cnt < V_SYNC_OFF));  // whole lines.
        pos.frame_start = (h_cnt == 10'd0) && (v_cnt == 10'd0);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raster <= video_pkg::RASTER_IDLE;
        end else begin
            raster <= pos;
        end
    end

endmodule

// File: sources.f
source/video_pkg.sv
source/game_pkg.sv
source/video_timing.sv
source/frog_control.sv
source/frog_sprite.sv
source/lane_background.sv
source/pixel_mixer.sv
source/frogger_display.sv
tb/frogger_display_assertions.sv
tb/frogger_display_tb.sv

// File: tb/frogger_display_assertions.sv
`timescale 1ns/100ps

module frogger_display_assertions #(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 480,
    parameter int H_SYNC   = 96
) (
    input logic                clk,
    input logic                rst_n,
    input video_pkg::color_t   color,
    input logic                hsync,
    input logic                active,
    input game_pkg::frog_pos_t frog
);

    int fail_count = 0;

    blank_is_black: assert property (@(posedge clk) disable iff (!rst_n)
        !active |-> color == 6'd0)
        else begin
            fail_count++;
            $error("color is not black outside the active area");
        end

    hsync_width: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(hsync) |-> !hsync [*H_SYNC] ##1 hsync)
        else begin
            fail_count++;
            $error("hsync pulse width differs from the sync interval");
        end

    frog_in_field: assert property (@(posedge clk) disable iff (!rst_n)
        frog.x <= 10'(H_ACTIVE - game_pkg::FROG_SIZE) &&
        frog.y <= 10'(V_ACTIVE - game_pkg::FROG_SIZE))
        else begin
            fail_count++;
            $error("frog position left the field");
        end

endmodule

bind frogger_display frogger_display_assertions #(
    .H_ACTIVE(H_ACTIVE),
    .V_ACTIVE(V_ACTIVE),
    .H_SYNC  (H_SYNC)
) i_frogger_display_assertions (
    .clk   (clk),
    .rst_n (rst_n),
    .color (color),
    .hsync (hsync),
    .active(active),
    .frog  (frog)
);

// File: tb/frogger_display_tb.sv
`timescale 1ns/100ps

module frogger_display_tb;

    localparam int H_ACTIVE     = 160;
    localparam int H_FRONT      = 4;
    localparam int H_SYNC       = 8;
    localparam int H_BACK       = 4;
    localparam int V_ACTIVE     = 128;
    localparam int V_FRONT      = 2;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 2;
    localparam int MOVE_STEP    = 8;
    localparam int SCROLL_STEP  = 4;
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int FRAME_CLOCKS = H_TOTAL * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
    localparam int X_START      = H_ACTIVE / 2 - 16;
    localparam int Y_START      = V_ACTIVE - 32;
    localparam int ROAD_ROW     = 2 * 32 + 15;  // first dash row of the road band.

    logic              clk;
    logic              rst_n;
    logic              btn_up;
    logic              btn_down;
    logic              btn_left;
    logic              btn_right;
    video_pkg::color_t color;
    logic              hsync;
    logic              vsync;
    logic              active;

    logic [5:0] frame_mem [V_ACTIVE][H_ACTIVE];
    logic       vsync_q;
    integer     seed;
    int         errors;
    int         checks;
    int         test_errors;
    int         vsync_rises;
    int         frame_idx;
    int         rows_seen;
    int         line_min;
    int         line_max;
    int         period_min;
    int         period_max;
    int         vsync_low;

    frogger_display #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .MOVE_STEP(MOVE_STEP), .SCROLL_STEP(SCROLL_STEP)
    ) i_frogger_display (
        .clk      (clk),
        .rst_n    (rst_n),
        .btn_up   (btn_up),
        .btn_down (btn_down),
        .btn_left (btn_left),
        .btn_right(btn_right),
        .color    (color),
        .hsync    (hsync),
        .vsync    (vsync),
        .active   (active)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // counts output frames where frame 0 is the one right after reset.
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vsync_q     <= 1'b1;
            vsync_rises <= 0;
        end else begin
            vsync_q <= vsync;
            if (vsync && !vsync_q) vsync_rises <= vsync_rises + 1;
        end
    end

    // ========================================
    // reference model
    // ========================================

    function automatic int sprite_color(input int col, input int row, input int fx, input int fy);
        int lx;
        int ly;
        lx = col - fx;
        ly = row - fy;
        if (col <= fx || col >= fx + 32 || row <= fy || row > fy + 32) return -1;
        if (ly >= 2 && ly <= 4 && ((lx >= 9 && lx <= 10) || (lx >= 21 && lx <= 22)))
            return game_pkg::PUPIL;
        if ((ly >= 2 && ly <= 6 && ((lx >= 6 && lx <= 8) || (lx >= 23 && lx <= 25))) ||
            (ly >= 5 && ly <= 6 && lx >= 6 && lx <= 10) ||
            (ly >= 4 && ly <= 6 && lx >= 21 && lx <= 25))
            return game_pkg::EYE_WHITE;
        if (ly >= 16 && ly <= 18 && lx >= 12 && lx <= 19) return game_pkg::MOUTH;
        if (ly >= 10 && ly <= 18 && lx >= 10 && lx <= 21) return game_pkg::YELLOW;
        if (ly >= 6 && ly <= 20 && lx >= 4 && lx <= 27) return game_pkg::LIGHT_GREEN;
        if (ly >= 20 && ly <= 25 && ((lx >= 2 && lx <= 7) || (lx >= 24 && lx <= 29)))
            return game_pkg::LIGHT_GREEN;  // legs.
        return -1;
    endfunction

    function automatic int band_color(input int col, input int row, input int offset);
        int band;
        int band_row;
        band     = row / 32;
        band_row = row % 32;
        if (band == 0 || band == V_ACTIVE / 32 - 1) return game_pkg::GRASS;
        if (band % 2 == 1) return game_pkg::WATER;
        if (band_row >= 15 && band_row <= 16 && (col + offset) % 32 < 16) return game_pkg::DASH;
        return game_pkg::ROAD;
    endfunction

    function automatic int expected_pixel(input int col, input int row, input int fx,
                                          input int fy, input int offset);
        int frog_px;
        frog_px = sprite_color(col, row, fx, fy);
        if (frog_px >= 0) return frog_px;
        return band_color(col, row, offset);
    endfunction

    // ========================================
    // helpers
    // ========================================

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            test_errors++;
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) $display("test %s: ok", name);
        else $display("test %s: %0d mismatches", name, test_errors);
        test_errors = 0;
    endtask

    // grabs the next output frame and measures its line and sync timing.
    task automatic capture_frame();
        int cycles;
        int row;
        int col;
        int last_fall;
        bit prev_active;
        bit prev_hsync;
        bit prev_vsync;
        bit started;
        bit done;
        cycles      = 0;
        row         = 0;
        col         = 0;
        last_fall   = -1;
        started     = 1'b0;
        done        = 1'b0;
        prev_active = active;
        prev_hsync  = hsync;
        prev_vsync  = vsync;
        line_min    = FRAME_CLOCKS;
        line_max    = 0;
        period_min  = FRAME_CLOCKS;
        period_max  = 0;
        vsync_low   = 0;
        while (!done && cycles < 2 * FRAME_CLOCKS) begin
            @(negedge clk);
            cycles++;
            if (!started && active && !prev_active) begin
                started   = 1'b1;
                frame_idx = vsync_rises;
            end
            if (started) begin
                if (active) begin
                    if (row < V_ACTIVE && col < H_ACTIVE) frame_mem[row][col] = color;
                    col++;
                end else if (prev_active) begin
                    line_min = (col < line_min) ? col : line_min;
                    line_max = (col > line_max) ? col : line_max;
                    row++;
                    col = 0;
                end
                if (!hsync && prev_hsync) begin
                    if (last_fall >= 0) begin
                        period_min = (cycles - last_fall < period_min) ? cycles - last_fall
                                                                       : period_min;
                        period_max = (cycles - last_fall > period_max) ? cycles - last_fall
                                                                       : period_max;
                    end
                    last_fall = cycles;
                end
                if (!vsync) vsync_low++;
                if (vsync && !prev_vsync) done = 1'b1;  // frame ends after vertical sync.
            end
            prev_active = active;
            prev_hsync  = hsync;
            prev_vsync  = vsync;
        end
        rows_seen = row;
        if (!done) begin
            $display("Timeout: no complete output frame within %0d clocks", 2 * FRAME_CLOCKS);
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    task automatic compare_region(input string name, input int c0, input int c1, input int r0,
                                  input int r1, input int fx, input int fy);
        int r;
        int c;
        for (r = r0; r <= r1 && r < V_ACTIVE; r++) begin
            for (c = c0; c <= c1 && c < H_ACTIVE; c++) begin
                check_value($sformatf("%s pixel (%0d,%0d)", name, c, r),
                            expected_pixel(c, r, fx, fy, SCROLL_STEP * frame_idx),
                            frame_mem[r][c]);
            end
        end
    endtask

    // ========================================
    // tests
    // ========================================

    task automatic test_reset();
        @(posedge clk);
        @(negedge clk);
        check_value("reset hsync", 1, hsync);
        check_value("reset vsync", 1, vsync);
        check_value("reset active", 0, active);
        check_value("reset color", 0, color);
        @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_value("after reset hsync", 1, hsync);
        check_value("after reset vsync", 1, vsync);
        check_value("after reset active", 0, active);
        check_value("after reset color", 0, color);
        end_test("reset state");
    endtask

    task automatic test_raster_timing();
        capture_frame();
        check_value("first frame index", 0, frame_idx);
        check_value("active lines", V_ACTIVE, rows_seen);
        check_value("shortest active line", H_ACTIVE, line_min);
        check_value("longest active line", H_ACTIVE, line_max);
        check_value("shortest line period", H_TOTAL, period_min);
        check_value("longest line period", H_TOTAL, period_max);
        check_value("vsync low clocks", V_SYNC * H_TOTAL, vsync_low);
        end_test("raster timing");
    endtask

    task automatic test_background();
        int col;
        int row;
        int n;
        n = 0;
        while (n < 64) begin
            col = $unsigned($random(seed)) % H_ACTIVE;
            row = $unsigned($random(seed)) % V_ACTIVE;
            if (col < X_START || col > X_START + 32 || row < Y_START) begin
                check_value($sformatf("background (%0d,%0d)", col, row),
                            band_color(col, row, SCROLL_STEP * frame_idx),
                            frame_mem[row][col]);
                n++;
            end
        end
        compare_region("road dash", 0, H_ACTIVE - 1, ROAD_ROW, ROAD_ROW + 1, X_START, Y_START);
        end_test("background");
    endtask

    task automatic test_frog_start();
        int r;
        int c;
        int mouth;
        int pupils;
        mouth  = 0;
        pupils = 0;
        compare_region("frog start", X_START, X_START + 32, Y_START, Y_START + 32,
                       X_START, Y_START);
        for (r = Y_START; r < V_ACTIVE; r++) begin
            for (c = X_START; c <= X_START + 32; c++) begin
                if (frame_mem[r][c] == game_pkg::MOUTH) mouth++;
                if (frame_mem[r][c] == game_pkg::PUPIL) pupils++;
            end
        end
        check_value("frog mouth pixels", 24, mouth);  // 8 columns by 3 rows.
        check_value("frog pupil pixels", 12, pupils);
        end_test("frog at reset position");
    endtask

    task automatic test_movement();
        @(posedge clk);
        btn_left <= 1'b1;
        @(posedge clk);
        btn_left <= 1'b0;
        capture_frame();
        compare_region("move left", X_START - MOVE_STEP, X_START + 32, Y_START, V_ACTIVE - 1,
                       X_START - MOVE_STEP, Y_START);
        @(posedge clk);
        btn_down  <= 1'b1;
        btn_right <= 1'b1;
        repeat (12) capture_frame();
        @(posedge clk);
        btn_down  <= 1'b0;
        btn_right <= 1'b0;
        // whole field so that a stray sprite pixel anywhere shows up.
        compare_region("clamped", 0, H_ACTIVE - 1, 0, V_ACTIVE - 1, H_ACTIVE - 32, V_ACTIVE - 32);
        end_test("movement and clamp");
    endtask

    task automatic test_scrolling();
        int first;
        capture_frame();
        first = frame_idx;
        compare_region("scroll first", 0, H_ACTIVE - 1, ROAD_ROW, ROAD_ROW,
                       H_ACTIVE - 32, V_ACTIVE - 32);
        capture_frame();
        check_value("consecutive frame index", first + 1, frame_idx);
        compare_region("scroll second", 0, H_ACTIVE - 1, ROAD_ROW, ROAD_ROW,
                       H_ACTIVE - 32, V_ACTIVE - 32);
        end_test("scrolling");
    endtask

    initial begin
        rst_n       = 1'b0;
        btn_up      = 1'b0;
        btn_down    = 1'b0;
        btn_left    = 1'b0;
        btn_right   = 1'b0;
        seed        = 83;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        frame_idx   = 0;
        test_reset();
        test_raster_timing();
        test_background();
        test_frog_start();
        test_movement();
        test_scrolling();
        check_value("assertion failures", 0,
                    i_frogger_display.i_frogger_display_assertions.fail_count);
        end_test("bound assertions");
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
